//--- source/dispatch_params.svh
// Size definitions shared by the dispatch stage, its queues and the ROB
// Included by the packages and by every module that sizes a port or an array
`ifndef DISPATCH_PARAMS_SVH
`define DISPATCH_PARAMS_SVH

`define ADDR_WIDTH      32
`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5

// ROB depth must stay a power of two, its pointers wrap on overflow
`define ROB_DEPTH       8
`define TAG_WIDTH       3

`define RS_DEPTH        4
`define IQ_DEPTH        4

`endif

//--- source/rv_isa_pkg.sv
// RV32I instruction set definitions: major opcodes and the bit positions of the
// instruction fields that dispatch needs for decode and renaming
`default_nettype none
`include "dispatch_params.svh"

package rv_isa_pkg;

    // Field positions inside a 32-bit instruction word
    localparam int OPCODE_LSB   = 0;
    localparam int OPCODE_WIDTH = 7;
    localparam int RD_LSB       = 7;
    localparam int RS1_LSB      = 15;
    localparam int RS2_LSB      = 20;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OPCODE_OPIMM  = 7'b0010011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_OP     = 7'b0110011,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011
    } rv_opcode_e;

    typedef logic [`REG_ADDR_WIDTH-1:0] rv_reg_t;

endpackage

`default_nettype wire

//--- source/dispatch_pkg.sv
// Microarchitecture records passed between the instruction queue, dispatch,
// the ROB and the reservation station
`default_nettype none
`include "dispatch_params.svh"

package dispatch_pkg;

    typedef enum logic [1:0] {
        ROB_OP_INT = 2'b00,
        ROB_OP_LD  = 2'b01,
        ROB_OP_ST  = 2'b10,
        ROB_OP_BR  = 2'b11
    } rob_op_e;

    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] iaddr;
        logic [`DATA_WIDTH-1:0] insn;
    } fetch_entry_t;

    // A source operand: either a known value or the tag of its producer
    typedef struct packed {
        logic                   rdy;
        logic [`TAG_WIDTH-1:0]  tag;
        logic [`DATA_WIDTH-1:0] data;
    } operand_t;

    typedef struct packed {
        rob_op_e                op;
        logic [`ADDR_WIDTH-1:0] iaddr;
        rv_isa_pkg::rv_reg_t    rdest;
    } rob_alloc_t;

    typedef struct packed {
        rv_isa_pkg::rv_opcode_e opcode;
        logic [`ADDR_WIDTH-1:0] iaddr;
        logic [`DATA_WIDTH-1:0] insn;
        operand_t               src0;
        operand_t               src1;
        logic [`TAG_WIDTH-1:0]  dst_tag;
    } rs_entry_t;

    typedef struct packed {
        logic [`TAG_WIDTH-1:0]  tag;
        logic [`DATA_WIDTH-1:0] data;
    } cdb_t;

    typedef struct packed {
        rob_op_e                op;
        logic [`ADDR_WIDTH-1:0] iaddr;
        rv_isa_pkg::rv_reg_t    rdest;
        logic [`DATA_WIDTH-1:0] data;
    } retire_t;

endpackage

`default_nettype wire

//--- source/insn_queue.sv
// Instruction queue between fetch and dispatch
// Circular buffer of address and instruction pairs with valid/ready on both sides
`timescale 1ns/10ps
`default_nettype none
`include "dispatch_params.svh"

module insn_queue (
    input  wire                              clk,
    input  wire                              i_rst_n,
    input  wire                              i_wr_valid,
    input  wire  dispatch_pkg::fetch_entry_t i_wr,
    output logic                             o_wr_ready,
    output logic                             o_rd_valid,
    output dispatch_pkg::fetch_entry_t       o_rd,
    input  wire                              i_rd_ready
);

    import dispatch_pkg::*;

    localparam int PTR_WIDTH = $clog2(`IQ_DEPTH);
    localparam int CNT_WIDTH = $clog2(`IQ_DEPTH + 1);

    fetch_entry_t         mem [`IQ_DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 push;
    logic                 pop;

    // A full queue still accepts a write when the head leaves in the same cycle
    assign o_wr_ready = (count != CNT_WIDTH'(`IQ_DEPTH)) | i_rd_ready;
    assign o_rd_valid = (count != '0);
    assign o_rd       = mem[rd_ptr];

    assign push = i_wr_valid & o_wr_ready;
    assign pop  = o_rd_valid & i_rd_ready;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_WIDTH'(push) - CNT_WIDTH'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_wr;
        end
    end

endmodule

`default_nettype wire

//--- source/dispatch.sv
// Dispatch stage: stages one instruction from the instruction queue, decodes it,
// allocates its ROB entry and writes the renamed instruction into the reservation station
// The staged instruction holds until the ROB and the station can both take it
`timescale 1ns/10ps
`default_nettype none
`include "dispatch_params.svh"

module dispatch (
    input  wire                              clk,
    input  wire                              i_rst_n,

    // Instruction queue side
    input  wire                              i_q_valid,
    input  wire  dispatch_pkg::fetch_entry_t i_q,
    output logic                             o_q_ready,

    // ROB side, with the combinational source lookup
    input  wire                              i_rob_ready,
    input  wire  [`TAG_WIDTH-1:0]            i_rob_tag,
    input  wire  dispatch_pkg::operand_t     i_rob_src [0:1],
    output dispatch_pkg::rob_alloc_t         o_rob_alloc,
    output rv_isa_pkg::rv_reg_t              o_rob_rsrc [0:1],

    // Reservation station side
    input  wire                              i_rs_ready,
    output dispatch_pkg::rs_entry_t          o_rs_entry,

    // Allocation strobe seen by both the ROB and the station
    output logic                             o_alloc_fire
);

    import rv_isa_pkg::*;
    import dispatch_pkg::*;

    fetch_entry_t stage;
    logic         stage_valid;
    logic         alloc_valid;
    logic         q_pop;
    rv_opcode_e   opcode;
    rv_reg_t      rdest;
    rv_reg_t      rsrc [0:1];
    logic         src_used [0:1];
    logic         has_rdest;
    rob_op_e      rob_op;
    operand_t     src [0:1];

    assign alloc_valid  = stage_valid;
    assign o_alloc_fire = alloc_valid & i_rob_ready & i_rs_ready;
    assign o_q_ready    = ~stage_valid | o_alloc_fire;
    assign q_pop        = i_q_valid & o_q_ready;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            stage_valid <= 1'b0;
        end else if (q_pop) begin
            stage_valid <= 1'b1;
        end else if (o_alloc_fire) begin
            stage_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            stage <= i_q;
        end
    end

    assign opcode  = rv_opcode_e'(stage.insn[OPCODE_LSB +: OPCODE_WIDTH]);
    assign rdest   = stage.insn[RD_LSB +: `REG_ADDR_WIDTH];
    assign rsrc[0] = stage.insn[RS1_LSB +: `REG_ADDR_WIDTH];
    assign rsrc[1] = stage.insn[RS2_LSB +: `REG_ADDR_WIDTH];

    // Which sources are read, whether rd is written, and the ROB class
    always_comb begin
        src_used[0] = 1'b0;
        src_used[1] = 1'b0;
        has_rdest   = 1'b0;
        rob_op      = ROB_OP_INT;
        case (opcode)
            OPCODE_OPIMM: begin
                src_used[0] = 1'b1;
                has_rdest   = 1'b1;
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                has_rdest = 1'b1;
            end
            OPCODE_OP: begin
                src_used[0] = 1'b1;
                src_used[1] = 1'b1;
                has_rdest   = 1'b1;
            end
            OPCODE_JAL: begin
                has_rdest = 1'b1;
                rob_op    = ROB_OP_BR;
            end
            OPCODE_JALR: begin
                src_used[0] = 1'b1;
                has_rdest   = 1'b1;
                rob_op      = ROB_OP_BR;
            end
            OPCODE_BRANCH: begin
                src_used[0] = 1'b1;
                src_used[1] = 1'b1;
                rob_op      = ROB_OP_BR;
            end
            OPCODE_LOAD: begin
                src_used[0] = 1'b1;
                has_rdest   = 1'b1;
                rob_op      = ROB_OP_LD;
            end
            OPCODE_STORE: begin
                src_used[0] = 1'b1;
                src_used[1] = 1'b1;
                rob_op      = ROB_OP_ST;
            end
            default: begin
                rob_op = ROB_OP_INT;
            end
        endcase
    end

    // An unread source goes out ready with zero data so it never blocks issue
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (src_used[i]) begin
                src[i] = i_rob_src[i];
            end else begin
                src[i] = '{rdy: 1'b1, tag: '0, data: '0};
            end
        end
    end

    assign o_rob_rsrc  = rsrc;
    assign o_rob_alloc = '{op: rob_op, iaddr: stage.iaddr, rdest: has_rdest ? rdest : '0};
    assign o_rs_entry  = '{
        opcode:  opcode,
        iaddr:   stage.iaddr,
        insn:    stage.insn,
        src0:    src[0],
        src1:    src[1],
        dst_tag: i_rob_tag
    };

endmodule

`default_nettype wire

//--- source/rename_rob.sv
// Reorder buffer with the rename map and the architectural register file
// Answers source lookups for dispatch, marks entries done from the CDB and
// retires one finished entry per cycle in program order
`timescale 1ns/10ps
`default_nettype none
`include "dispatch_params.svh"

module rename_rob (
    input  wire                            clk,
    input  wire                            i_rst_n,
    input  wire                            i_alloc_fire,
    input  wire  dispatch_pkg::rob_alloc_t i_alloc,
    output logic                           o_ready,
    output logic [`TAG_WIDTH-1:0]          o_tag,
    input  wire  rv_isa_pkg::rv_reg_t      i_rsrc [0:1],
    output dispatch_pkg::operand_t         o_src [0:1],
    input  wire                            i_cdb_valid,
    input  wire  dispatch_pkg::cdb_t       i_cdb,
    output logic                           o_retire_valid,
    output dispatch_pkg::retire_t          o_retire
);

    import rv_isa_pkg::*;
    import dispatch_pkg::*;

    localparam int NUM_REGS  = 1 << `REG_ADDR_WIDTH;
    localparam int CNT_WIDTH = $clog2(`ROB_DEPTH + 1);

    rob_op_e                rob_op    [`ROB_DEPTH];
    logic [`ADDR_WIDTH-1:0] rob_iaddr [`ROB_DEPTH];
    rv_reg_t                rob_rdest [`ROB_DEPTH];
    logic [`DATA_WIDTH-1:0] rob_data  [`ROB_DEPTH];
    logic                   rob_done  [`ROB_DEPTH];
    logic                   map_pend  [NUM_REGS];
    logic [`TAG_WIDTH-1:0]  map_tag   [NUM_REGS];
    logic [`DATA_WIDTH-1:0] arch_regs [NUM_REGS];
    logic [`TAG_WIDTH-1:0]  head;
    logic [`TAG_WIDTH-1:0]  tail;
    logic [CNT_WIDTH-1:0]   count;
    logic [`TAG_WIDTH-1:0]  src_tag [0:1];
    rv_reg_t                ret_rdest;

    assign o_ready        = (count != CNT_WIDTH'(`ROB_DEPTH));
    assign o_tag          = tail;
    assign o_retire_valid = (count != '0) && rob_done[head];
    assign ret_rdest      = rob_rdest[head];
    assign o_retire       = '{
        op:    rob_op[head],
        iaddr: rob_iaddr[head],
        rdest: ret_rdest,
        data:  (ret_rdest == '0) ? '0 : rob_data[head]
    };

    assign src_tag[0] = map_tag[i_rsrc[0]];
    assign src_tag[1] = map_tag[i_rsrc[1]];

    // x0 is never mapped and never written, so it always reads ready as zero
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            o_src[i] = '{rdy: 1'b1, tag: src_tag[i], data: arch_regs[i_rsrc[i]]};
            if (map_pend[i_rsrc[i]]) begin
                if (rob_done[src_tag[i]]) begin
                    o_src[i].data = rob_data[src_tag[i]];
                end else if (i_cdb_valid && (i_cdb.tag == src_tag[i])) begin
                    o_src[i].data = i_cdb.data;
                end else begin
                    o_src[i].rdy  = 1'b0;
                    o_src[i].data = '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                map_pend[r]  <= 1'b0;
                arch_regs[r] <= '0;
            end
            for (int e = 0; e < `ROB_DEPTH; e++) begin
                rob_done[e] <= 1'b0;
            end
        end else begin
            if (o_retire_valid) begin
                head <= head + 1'b1;
                if (ret_rdest != '0) begin
                    arch_regs[ret_rdest] <= rob_data[head];
                end
                // A younger writer of the same register keeps the mapping
                if (map_tag[ret_rdest] == head) begin
                    map_pend[ret_rdest] <= 1'b0;
                end
            end
            if (i_cdb_valid) begin
                rob_done[i_cdb.tag] <= 1'b1;
            end
            if (i_alloc_fire) begin
                tail           <= tail + 1'b1;
                rob_done[tail] <= 1'b0;
                if (i_alloc.rdest != '0) begin
                    map_pend[i_alloc.rdest] <= 1'b1;
                end
            end
            count <= count + CNT_WIDTH'(i_alloc_fire) - CNT_WIDTH'(o_retire_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (i_alloc_fire) begin
            rob_op[tail]           <= i_alloc.op;
            rob_iaddr[tail]        <= i_alloc.iaddr;
            rob_rdest[tail]        <= i_alloc.rdest;
            map_tag[i_alloc.rdest] <= tail;
        end
        if (i_cdb_valid) begin
            rob_data[i_cdb.tag] <= i_cdb.data;
        end
    end

endmodule

`default_nettype wire

//--- source/reservation_station.sv
// Reservation station: renamed instructions wait here for their operands
// Waiting operands are woken from the CDB and the oldest fully ready slot issues
`timescale 1ns/10ps
`default_nettype none
`include "dispatch_params.svh"

module reservation_station (
    input  wire                           clk,
    input  wire                           i_rst_n,
    input  wire                           i_alloc_fire,
    input  wire  dispatch_pkg::rs_entry_t i_entry,
    output logic                          o_ready,
    input  wire                           i_cdb_valid,
    input  wire  dispatch_pkg::cdb_t      i_cdb,
    output logic                          o_issue_valid,
    output dispatch_pkg::rs_entry_t       o_issue,
    input  wire                           i_issue_ready
);

    import dispatch_pkg::*;

    localparam int IDX_WIDTH = $clog2(`RS_DEPTH);
    localparam int CNT_WIDTH = $clog2(`RS_DEPTH + 1);

    rs_entry_t            slot       [`RS_DEPTH];
    logic                 slot_valid [`RS_DEPTH];
    // Age counts the valid slots allocated before this one, so 0 is the oldest
    logic [IDX_WIDTH-1:0] slot_age   [`RS_DEPTH];
    logic [IDX_WIDTH-1:0] issue_idx;
    logic [IDX_WIDTH-1:0] issue_age;
    logic [IDX_WIDTH-1:0] free_idx;
    logic                 free_found;
    logic [CNT_WIDTH-1:0] occupancy;
    logic                 issue_fire;

    always_comb begin
        o_issue_valid = 1'b0;
        issue_idx     = '0;
        issue_age     = '0;
        free_found    = 1'b0;
        free_idx      = '0;
        occupancy     = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (slot_valid[i]) begin
                occupancy = occupancy + 1'b1;
                if (slot[i].src0.rdy && slot[i].src1.rdy &&
                    (!o_issue_valid || (slot_age[i] < issue_age))) begin
                    o_issue_valid = 1'b1;
                    issue_idx     = IDX_WIDTH'(i);
                    issue_age     = slot_age[i];
                end
            end else if (!free_found) begin
                free_found = 1'b1;
                free_idx   = IDX_WIDTH'(i);
            end
        end
    end

    assign o_ready    = free_found;
    assign o_issue    = slot[issue_idx];
    assign issue_fire = o_issue_valid & i_issue_ready;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                slot_valid[i] <= 1'b0;
                slot_age[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (issue_fire && (slot_age[i] > issue_age)) begin
                    slot_age[i] <= slot_age[i] - 1'b1;
                end
                if (issue_fire && (IDX_WIDTH'(i) == issue_idx)) begin
                    slot_valid[i] <= 1'b0;
                end
                if (i_alloc_fire && (IDX_WIDTH'(i) == free_idx)) begin
                    slot_valid[i] <= 1'b1;
                    slot_age[i]   <= IDX_WIDTH'(occupancy - CNT_WIDTH'(issue_fire));
                end
            end
        end
    end

    // Capture new entries and wake operands whose producer is on the CDB
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (i_alloc_fire && (IDX_WIDTH'(i) == free_idx)) begin
                slot[i] <= i_entry;
            end else if (i_cdb_valid) begin
                if (!slot[i].src0.rdy && (slot[i].src0.tag == i_cdb.tag)) begin
                    slot[i].src0.rdy  <= 1'b1;
                    slot[i].src0.data <= i_cdb.data;
                end
                if (!slot[i].src1.rdy && (slot[i].src1.tag == i_cdb.tag)) begin
                    slot[i].src1.rdy  <= 1'b1;
                    slot[i].src1.data <= i_cdb.data;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dispatch_top.sv
// Top level of the dispatch block: instruction queue, dispatch stage, ROB and
// reservation station, with fetch, issue, CDB and retire ports to the outside
`timescale 1ns/10ps
`default_nettype none
`include "dispatch_params.svh"

module dispatch_top (
    input  wire                              clk,
    input  wire                              i_rst_n,
    input  wire                              i_fetch_valid,
    input  wire  dispatch_pkg::fetch_entry_t i_fetch,
    output logic                             o_fetch_ready,
    input  wire                              i_cdb_valid,
    input  wire  dispatch_pkg::cdb_t         i_cdb,
    output logic                             o_issue_valid,
    output dispatch_pkg::rs_entry_t          o_issue,
    input  wire                              i_issue_ready,
    output logic                             o_retire_valid,
    output dispatch_pkg::retire_t            o_retire
);

    import rv_isa_pkg::*;
    import dispatch_pkg::*;

    logic                  q_valid;
    fetch_entry_t          q_entry;
    logic                  q_ready;
    logic                  alloc_fire;
    rob_alloc_t            rob_alloc;
    rv_reg_t               rob_rsrc [0:1];
    operand_t              rob_src  [0:1];
    logic                  rob_ready;
    logic [`TAG_WIDTH-1:0] rob_tag;
    logic                  rs_ready;
    rs_entry_t             rs_entry;

    insn_queue insn_queue_inst (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_wr_valid (i_fetch_valid),
        .i_wr       (i_fetch),
        .o_wr_ready (o_fetch_ready),
        .o_rd_valid (q_valid),
        .o_rd       (q_entry),
        .i_rd_ready (q_ready)
    );

    dispatch dispatch_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_q_valid    (q_valid),
        .i_q          (q_entry),
        .o_q_ready    (q_ready),
        .i_rob_ready  (rob_ready),
        .i_rob_tag    (rob_tag),
        .i_rob_src    (rob_src),
        .o_rob_alloc  (rob_alloc),
        .o_rob_rsrc   (rob_rsrc),
        .i_rs_ready   (rs_ready),
        .o_rs_entry   (rs_entry),
        .o_alloc_fire (alloc_fire)
    );

    rename_rob rename_rob_inst (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_alloc_fire   (alloc_fire),
        .i_alloc        (rob_alloc),
        .o_ready        (rob_ready),
        .o_tag          (rob_tag),
        .i_rsrc         (rob_rsrc),
        .o_src          (rob_src),
        .i_cdb_valid    (i_cdb_valid),
        .i_cdb          (i_cdb),
        .o_retire_valid (o_retire_valid),
        .o_retire       (o_retire)
    );

    reservation_station reservation_station_inst (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_alloc_fire  (alloc_fire),
        .i_entry       (rs_entry),
        .o_ready       (rs_ready),
        .i_cdb_valid   (i_cdb_valid),
        .i_cdb         (i_cdb),
        .o_issue_valid (o_issue_valid),
        .o_issue       (o_issue),
        .i_issue_ready (i_issue_ready)
    );

endmodule

`default_nettype wire

//--- verif/dispatch_tb.sv
// Testbench for dispatch_top, acting as the fetch unit and the execution unit
// Instructions come from a table; issued entries get their CDB result in issue order
// and every retire is compared with the table in program order
`timescale 1ns/10ps
`default_nettype none
`include "dispatch_params.svh"

module dispatch_tb;

    import rv_isa_pkg::*;
    import dispatch_pkg::*;

    localparam int          NUM_ROWS    = 16;
    localparam int          CYCLE_LIMIT = 40 * NUM_ROWS;
    localparam logic [31:0] BASE_ADDR   = 32'h0000_1000;

    // One table row: the instruction fields, its CDB result and the expected ROB record
    typedef struct packed {
        rv_opcode_e  opc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] result;
        rob_op_e     op;
        logic [4:0]  rdest;
        logic        use0;
        logic        use1;
    } row_t;

    logic         clk;
    logic         i_rst_n;
    logic         i_fetch_valid;
    fetch_entry_t i_fetch;
    logic         o_fetch_ready;
    logic         i_cdb_valid;
    cdb_t         i_cdb;
    logic         o_issue_valid;
    rs_entry_t    o_issue;
    logic         i_issue_ready;
    logic         o_retire_valid;
    retire_t      o_retire;

    row_t         rows [NUM_ROWS];
    logic         issued [NUM_ROWS];
    int           cdb_queue [$];
    int           row_count;
    int           fetch_idx;
    int           retire_idx;
    int           cycle;
    int           stall_left;
    int           last_indep;
    int           cdb_idx;
    logic         saw_fetch_stall;
    logic         fetch_ready_now;
    logic         issue_valid_now;
    rs_entry_t    issue_now;
    logic         retire_valid_now;
    retire_t      retire_now;

    dispatch_top dispatch_top_inst (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_fetch_valid  (i_fetch_valid),
        .i_fetch        (i_fetch),
        .o_fetch_ready  (o_fetch_ready),
        .i_cdb_valid    (i_cdb_valid),
        .i_cdb          (i_cdb),
        .o_issue_valid  (o_issue_valid),
        .o_issue        (o_issue),
        .i_issue_ready  (i_issue_ready),
        .o_retire_valid (o_retire_valid),
        .o_retire       (o_retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_error(input string what);
        $display("ERROR: %s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic add_row(input rv_opcode_e opc, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [31:0] result, input rob_op_e op,
                           input logic [4:0] rdest, input logic use0, input logic use1);
        rows[row_count] = '{opc: opc, rd: rd, rs1: rs1, rs2: rs2, result: result, op: op,
                            rdest: rdest, use0: use0, use1: use1};
        issued[row_count] = 1'b0;
        row_count++;
    endtask

    function automatic logic [31:0] row_addr(input int idx);
        return BASE_ADDR + 32'(idx * 4);
    endfunction

    function automatic logic [31:0] encode_insn(input row_t r);
        return {7'b0, r.rs2, r.rs1, 3'b000, r.rd, r.opc};
    endfunction

    // True when an older row writes register r, so the operand waits on a producer
    function automatic logic has_producer(input int idx, input logic [4:0] r);
        logic found;
        int   j;
        found = 1'b0;
        for (j = 0; j < idx; j++) begin
            if (r != 5'd0 && rows[j].rdest == r) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Register value in program order just before row idx, from the table results
    function automatic logic [31:0] value_before(input int idx, input logic [4:0] r);
        logic [31:0] value;
        int          j;
        value = '0;
        for (j = 0; j < idx; j++) begin
            if (r != 5'd0 && rows[j].rdest == r) begin
                value = rows[j].result;
            end
        end
        return value;
    endfunction

    function automatic logic is_independent(input int idx);
        return !(rows[idx].use0 && has_producer(idx, rows[idx].rs1)) &&
               !(rows[idx].use1 && has_producer(idx, rows[idx].rs2));
    endfunction

    task automatic check_issue(input rs_entry_t e);
        logic [31:0] offset;
        logic [31:0] exp0;
        logic [31:0] exp1;
        int          idx;
        offset = e.iaddr - BASE_ADDR;
        if (offset[1:0] != 2'b00 || (offset >> 2) >= NUM_ROWS) begin
            stop_with_error("issued an instruction address that is not in the table");
        end
        idx = int'(offset >> 2);
        if (issued[idx]) begin
            stop_with_error("an instruction issued more than once");
        end
        issued[idx] = 1'b1;
        exp0 = rows[idx].use0 ? value_before(idx, rows[idx].rs1) : 32'h0;
        exp1 = rows[idx].use1 ? value_before(idx, rows[idx].rs2) : 32'h0;
        check_value("o_issue.insn", e.insn, encode_insn(rows[idx]));
        check_value("o_issue.opcode", e.opcode, rows[idx].opc);
        check_value("o_issue.dst_tag", e.dst_tag, idx % `ROB_DEPTH);
        check_value("o_issue.src0.rdy", e.src0.rdy, 1);
        check_value("o_issue.src0.data", e.src0.data, exp0);
        check_value("o_issue.src1.rdy", e.src1.rdy, 1);
        check_value("o_issue.src1.data", e.src1.data, exp1);
        // Rows with no pending producer are ready at allocation and must leave in age order
        if (is_independent(idx)) begin
            if (idx < last_indep) begin
                stop_with_error("an independent instruction issued ahead of an older one");
            end
            last_indep = idx;
        end
        cdb_queue.push_back(idx);
    endtask

    task automatic check_retire(input retire_t r);
        row_t exp_row;
        exp_row = rows[retire_idx];
        if (!issued[retire_idx]) begin
            stop_with_error("an instruction retired before it was issued");
        end
        check_value("o_retire.op", r.op, exp_row.op);
        check_value("o_retire.iaddr", r.iaddr, row_addr(retire_idx));
        check_value("o_retire.rdest", r.rdest, exp_row.rdest);
        check_value("o_retire.data", r.data, (exp_row.rdest == 5'd0) ? 32'h0 : exp_row.result);
        retire_idx++;
    endtask

    initial begin
        void'($urandom(62));
        i_rst_n       = 1'b0;
        i_fetch_valid = 1'b0;
        i_fetch       = '0;
        i_cdb_valid   = 1'b0;
        i_cdb         = '0;
        i_issue_ready = 1'b0;
        row_count     = 0;
        fetch_idx     = 0;
        retire_idx    = 0;
        cycle         = 0;
        stall_left    = 0;
        last_indep    = -1;
        saw_fetch_stall = 1'b0;

        // Independent work first, then chains through renamed registers
        // Unused source fields of LUI and OPIMM name registers that an older row writes
        add_row(OPCODE_OPIMM,  5'd1,  5'd0,  5'd9,  32'h0000_0011, ROB_OP_INT, 5'd1,  1, 0);
        add_row(OPCODE_LUI,    5'd2,  5'd1,  5'd6,  32'h1234_5000, ROB_OP_INT, 5'd2,  0, 0);
        add_row(OPCODE_JAL,    5'd3,  5'd1,  5'd2,  32'h0000_100C, ROB_OP_BR,  5'd3,  0, 0);
        add_row(OPCODE_AUIPC,  5'd4,  5'd0,  5'd0,  32'h0000_200C, ROB_OP_INT, 5'd4,  0, 0);
        add_row(OPCODE_OP,     5'd5,  5'd1,  5'd2,  32'h1234_5011, ROB_OP_INT, 5'd5,  1, 1);
        add_row(OPCODE_STORE,  5'd7,  5'd5,  5'd3,  32'h0000_DEAD, ROB_OP_ST,  5'd0,  1, 1);
        add_row(OPCODE_BRANCH, 5'd9,  5'd4,  5'd5,  32'h0000_0001, ROB_OP_BR,  5'd0,  1, 1);
        add_row(OPCODE_LOAD,   5'd6,  5'd5,  5'd12, 32'h0000_0066, ROB_OP_LD,  5'd6,  1, 0);
        add_row(OPCODE_OPIMM,  5'd1,  5'd6,  5'd5,  32'h0000_0077, ROB_OP_INT, 5'd1,  1, 0);
        add_row(OPCODE_JALR,   5'd7,  5'd1,  5'd0,  32'h0000_1028, ROB_OP_BR,  5'd7,  1, 0);
        add_row(OPCODE_OP,     5'd8,  5'd1,  5'd7,  32'h0000_0088, ROB_OP_INT, 5'd8,  1, 1);
        add_row(OPCODE_OPIMM,  5'd0,  5'd8,  5'd0,  32'h0000_0099, ROB_OP_INT, 5'd0,  1, 0);
        add_row(OPCODE_OP,     5'd9,  5'd0,  5'd0,  32'h0000_00A9, ROB_OP_INT, 5'd9,  1, 1);
        add_row(OPCODE_LUI,    5'd10, 5'd0,  5'd0,  32'hAAAA_0000, ROB_OP_INT, 5'd10, 0, 0);
        add_row(OPCODE_OP,     5'd11, 5'd9,  5'd10, 32'h0000_00BB, ROB_OP_INT, 5'd11, 1, 1);
        add_row(OPCODE_STORE,  5'd3,  5'd11, 5'd8,  32'h0000_00CC, ROB_OP_ST,  5'd0,  1, 1);

        repeat (4) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        check_value("o_issue_valid", o_issue_valid, 0);
        check_value("o_retire_valid", o_retire_valid, 0);
        check_value("o_fetch_ready", o_fetch_ready, 1);

        while (retire_idx < NUM_ROWS) begin
            @(negedge clk);
            cycle++;
            if (cycle > CYCLE_LIMIT) begin
                stop_with_error("timeout, not every instruction retired within the cycle limit");
            end
            // DUT outputs only move after a rising edge, so they are settled here
            fetch_ready_now  = o_fetch_ready;
            issue_valid_now  = o_issue_valid;
            issue_now        = o_issue;
            retire_valid_now = o_retire_valid;
            retire_now       = o_retire;

            if (retire_valid_now) begin
                check_retire(retire_now);
            end

            if (cdb_queue.size() != 0) begin
                cdb_idx     = cdb_queue.pop_front();
                i_cdb_valid = 1'b1;
                i_cdb       = '{tag: `TAG_WIDTH'(cdb_idx % `ROB_DEPTH),
                                data: rows[cdb_idx].result};
            end else begin
                i_cdb_valid = 1'b0;
            end

            // Hold issue back at the start so the station, dispatch and the queue fill up
            if (cycle <= 24) begin
                i_issue_ready = 1'b0;
            end else if (stall_left != 0) begin
                i_issue_ready = 1'b0;
                stall_left--;
            end else begin
                i_issue_ready = 1'b1;
                if ($urandom % 8 == 0) begin
                    stall_left = 2 + int'($urandom % 6);
                end
            end
            if (issue_valid_now && i_issue_ready) begin
                check_issue(issue_now);
            end

            if (fetch_idx < NUM_ROWS) begin
                i_fetch_valid = 1'b1;
                i_fetch       = '{iaddr: row_addr(fetch_idx), insn: encode_insn(rows[fetch_idx])};
                if (fetch_ready_now) begin
                    fetch_idx++;
                end else begin
                    saw_fetch_stall = 1'b1;
                end
            end else begin
                i_fetch_valid = 1'b0;
            end
        end

        if (!saw_fetch_stall) begin
            stop_with_error("o_fetch_ready never fell while the pipeline was full");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+source
source/rv_isa_pkg.sv
source/dispatch_pkg.sv
source/insn_queue.sv
source/dispatch.sv
source/rename_rob.sv
source/reservation_station.sv
source/dispatch_top.sv
verif/dispatch_tb.sv
